// ==== src/hci_reg_pkg.sv ====
// ********************
// Register map and CSR port types of the HCI queue block
// ********************
`default_nettype none

package hci_reg_pkg;

  localparam int unsigned CsrAddrWidth = 12;
  localparam int unsigned CsrDataWidth = 32;

  localparam logic [CsrAddrWidth-1:0] RegResetCtrl = 12'h010;
  localparam logic [CsrAddrWidth-1:0] RegQueueThld = 12'h020;
  localparam logic [CsrAddrWidth-1:0] RegCmdPort   = 12'h030;
  localparam logic [CsrAddrWidth-1:0] RegRespPort  = 12'h034;

  // Reset control bits
  localparam int unsigned CmdRstBit  = 1;
  localparam int unsigned RespRstBit = 2;

  // Threshold register fields
  localparam int unsigned CmdThldLsb  = 0;
  localparam int unsigned CmdThldMsb  = 7;
  localparam int unsigned RespThldLsb = 8;
  localparam int unsigned RespThldMsb = 15;

  typedef enum logic [2:0] {
    SelNone,
    SelResetCtrl,
    SelQueueThld,
    SelCmdPort,
    SelRespPort
  } reg_sel_e;

  typedef struct packed {
    logic                    req;
    logic                    is_wr;
    logic [CsrAddrWidth-1:0] addr;
    logic [CsrDataWidth-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic                    rd_ack;
    logic                    wr_ack;
    logic                    err;   // Valid with either ack
    logic [CsrDataWidth-1:0] rdata;
  } csr_rsp_t;

endpackage

`default_nettype wire

// ==== src/hci_queue_pkg.sv ====
// ********************
// Queue sizes, flush states and status type
// Shared by the queues, the register block and the top level
// ********************
`default_nettype none

package hci_queue_pkg;

  // Entries per queue
  localparam int unsigned CmdDepth  = 8;
  localparam int unsigned RespDepth = 8;

  // Entry widths, a command is two register dwords
  localparam int unsigned CmdWidth  = 64;
  localparam int unsigned RespWidth = 32;

  localparam int unsigned ThldWidth = 8;

  // Soft reset sequence of one queue
  typedef enum logic [1:0] {
    FlushIdle,
    FlushRun,   // Pointers cleared on exit
    FlushDone   // Done pulse to the register block
  } flush_state_e;

  // Status seen by the bus controller
  typedef struct packed {
    logic                 full;
    logic                 empty;
    logic                 thld_trig;
    logic [ThldWidth-1:0] thld;      // Clamped threshold
  } queue_status_t;

endpackage

`default_nettype wire

// ==== src/hci_queue.sv ====
// ********************
// Circular FIFO with ready threshold and flush sequence
// Used for both the command and the response queue
// ********************
`default_nettype none

module hci_queue #(
  parameter int unsigned Depth     = 8,
  parameter int unsigned DataWidth = 32
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  input  logic                                push_i,
  input  logic [DataWidth-1:0]                wdata_i,
  output logic                                full_o,

  input  logic                                pop_i,
  output logic [DataWidth-1:0]                rdata_o,
  output logic                                empty_o,

  input  logic [hci_queue_pkg::ThldWidth-1:0] thld_i,
  output logic [hci_queue_pkg::ThldWidth-1:0] thld_eff_o,
  output logic                                thld_trig_o,
  input  logic                                count_free_i,

  input  logic                                flush_i,
  output logic                                flush_done_o
);

  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);
  localparam int unsigned ThldW = hci_queue_pkg::ThldWidth;

  logic [DataWidth-1:0] mem_q [Depth];
  logic [PtrW-1:0]      wptr_q;
  logic [PtrW-1:0]      rptr_q;
  logic [CntW-1:0]      count_q;
  logic [CntW-1:0]      trig_cnt;
  logic                 do_push;
  logic                 do_pop;

  hci_queue_pkg::flush_state_e state_q, state_d;

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign rdata_o = mem_q[rptr_q];  // Head entry

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (state_q == hci_queue_pkg::FlushRun) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Clamp to 1..Depth
  always_comb begin
    if (thld_i == '0) begin
      thld_eff_o = ThldW'(1);
    end else if (thld_i > Depth) begin
      thld_eff_o = ThldW'(Depth);
    end else begin
      thld_eff_o = thld_i;
    end
  end

  // Command side counts free slots, response side stored entries
  assign trig_cnt    = count_free_i ? CntW'(Depth) - count_q : count_q;
  assign thld_trig_o = (trig_cnt >= thld_eff_o);

  always_comb begin
    state_d = state_q;
    case (state_q)
      hci_queue_pkg::FlushIdle: begin
        if (flush_i) begin
          state_d = hci_queue_pkg::FlushRun;
        end
      end
      hci_queue_pkg::FlushRun:  state_d = hci_queue_pkg::FlushDone;
      hci_queue_pkg::FlushDone: state_d = hci_queue_pkg::FlushIdle;
      default:                  state_d = hci_queue_pkg::FlushIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= hci_queue_pkg::FlushIdle;
    end else begin
      state_q <= state_d;
    end
  end

  assign flush_done_o = (state_q == hci_queue_pkg::FlushDone);

endmodule

`default_nettype wire

// ==== src/hci_csr.sv ====
// ********************
// Register block: decode, acks, threshold and reset registers
// Assembles command dwords and serves response port reads
// ********************
`default_nettype none

module hci_csr (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  input  hci_reg_pkg::csr_req_t                csr_req_i,
  output hci_reg_pkg::csr_rsp_t                csr_rsp_o,

  output logic                                 cmd_push_o,
  output logic [hci_queue_pkg::CmdWidth-1:0]   cmd_data_o,
  input  logic                                 cmd_full_i,

  output logic                                 resp_pop_o,
  input  logic [hci_queue_pkg::RespWidth-1:0]  resp_data_i,
  input  logic                                 resp_empty_i,

  output logic [hci_queue_pkg::ThldWidth-1:0]  cmd_thld_o,
  output logic [hci_queue_pkg::ThldWidth-1:0]  resp_thld_o,
  input  logic [hci_queue_pkg::ThldWidth-1:0]  cmd_thld_eff_i,
  input  logic [hci_queue_pkg::ThldWidth-1:0]  resp_thld_eff_i,

  output logic                                 cmd_flush_o,
  output logic                                 resp_flush_o,
  input  logic                                 cmd_flush_done_i,
  input  logic                                 resp_flush_done_i
);

  hci_reg_pkg::reg_sel_e sel;

  logic                                  rd;
  logic                                  wr;
  logic                                  err_d;
  logic [hci_reg_pkg::CsrDataWidth-1:0]  rdata_d;
  logic                                  rd_ack_q;
  logic                                  wr_ack_q;
  logic                                  err_q;
  logic [hci_reg_pkg::CsrDataWidth-1:0]  rdata_q;
  logic [hci_queue_pkg::ThldWidth-1:0]   cmd_thld_q;
  logic [hci_queue_pkg::ThldWidth-1:0]   resp_thld_q;
  logic                                  thld_sw_we;
  logic [1:0]                            thld_wb_q;
  logic                                  rst_sw_we;
  logic                                  cmd_rst_q;
  logic                                  resp_rst_q;
  logic                                  cmd_wr;
  logic                                  cmd_phase_q;  // High after the low dword
  logic [hci_reg_pkg::CsrDataWidth-1:0]  cmd_lo_q;

  always_comb begin
    case (csr_req_i.addr)
      hci_reg_pkg::RegResetCtrl: sel = hci_reg_pkg::SelResetCtrl;
      hci_reg_pkg::RegQueueThld: sel = hci_reg_pkg::SelQueueThld;
      hci_reg_pkg::RegCmdPort:   sel = hci_reg_pkg::SelCmdPort;
      hci_reg_pkg::RegRespPort:  sel = hci_reg_pkg::SelRespPort;
      default:                   sel = hci_reg_pkg::SelNone;
    endcase
  end

  assign rd = csr_req_i.req & ~csr_req_i.is_wr;
  assign wr = csr_req_i.req & csr_req_i.is_wr;

  assign thld_sw_we = wr & (sel == hci_reg_pkg::SelQueueThld);
  assign rst_sw_we  = wr & (sel == hci_reg_pkg::SelResetCtrl);
  assign cmd_wr     = wr & (sel == hci_reg_pkg::SelCmdPort);

  assign cmd_push_o = cmd_wr & cmd_phase_q & ~cmd_full_i;
  assign cmd_data_o = {csr_req_i.wdata, cmd_lo_q};  // First dword is the low half
  assign resp_pop_o = rd & (sel == hci_reg_pkg::SelRespPort) & ~resp_empty_i;

  always_comb begin
    err_d   = 1'b0;
    rdata_d = '0;
    case (sel)
      hci_reg_pkg::SelResetCtrl: begin
        rdata_d[hci_reg_pkg::CmdRstBit]  = cmd_rst_q;
        rdata_d[hci_reg_pkg::RespRstBit] = resp_rst_q;
      end
      hci_reg_pkg::SelQueueThld: begin
        rdata_d[hci_reg_pkg::CmdThldMsb:hci_reg_pkg::CmdThldLsb]   = cmd_thld_eff_i;
        rdata_d[hci_reg_pkg::RespThldMsb:hci_reg_pkg::RespThldLsb] = resp_thld_eff_i;
      end
      hci_reg_pkg::SelCmdPort: begin
        err_d = ~csr_req_i.is_wr | (cmd_phase_q & cmd_full_i);
      end
      hci_reg_pkg::SelRespPort: begin
        err_d = csr_req_i.is_wr | resp_empty_i;
        if (!resp_empty_i) begin
          rdata_d = resp_data_i;
        end
      end
      default: err_d = 1'b1;  // Unmapped
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ack_q <= 1'b0;
      wr_ack_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rd_ack_q <= rd;
      wr_ack_q <= wr;
      err_q    <= csr_req_i.req & err_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rd ? rdata_d : '0;
  end

  assign csr_rsp_o = '{rd_ack: rd_ack_q, wr_ack: wr_ack_q, err: err_q, rdata: rdata_q};

  // Clamped values come back two cycles after a software write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      thld_wb_q   <= '0;
      cmd_thld_q  <= 8'd1;
      resp_thld_q <= 8'd1;
    end else begin
      thld_wb_q <= {thld_wb_q[0], thld_sw_we};
      if (thld_sw_we) begin
        cmd_thld_q  <= csr_req_i.wdata[hci_reg_pkg::CmdThldMsb:hci_reg_pkg::CmdThldLsb];
        resp_thld_q <= csr_req_i.wdata[hci_reg_pkg::RespThldMsb:hci_reg_pkg::RespThldLsb];
      end else if (thld_wb_q[1]) begin
        cmd_thld_q  <= cmd_thld_eff_i;
        resp_thld_q <= resp_thld_eff_i;
      end
    end
  end

  assign cmd_thld_o  = cmd_thld_q;
  assign resp_thld_o = resp_thld_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_rst_q  <= 1'b0;
      resp_rst_q <= 1'b0;
    end else begin
      if (rst_sw_we && csr_req_i.wdata[hci_reg_pkg::CmdRstBit]) begin
        cmd_rst_q <= 1'b1;
      end else if (cmd_flush_done_i) begin
        cmd_rst_q <= 1'b0;
      end
      if (rst_sw_we && csr_req_i.wdata[hci_reg_pkg::RespRstBit]) begin
        resp_rst_q <= 1'b1;
      end else if (resp_flush_done_i) begin
        resp_rst_q <= 1'b0;
      end
    end
  end

  assign cmd_flush_o  = cmd_rst_q;
  assign resp_flush_o = resp_rst_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_phase_q <= 1'b0;
      cmd_lo_q    <= '0;
    end else if (cmd_flush_o) begin
      cmd_phase_q <= 1'b0;  // Drop a half command
      cmd_lo_q    <= '0;
    end else if (cmd_wr) begin
      if (!cmd_phase_q) begin
        cmd_lo_q    <= csr_req_i.wdata;
        cmd_phase_q <= 1'b1;
      end else begin
        cmd_phase_q <= 1'b0;  // Pushed, or discarded when full
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/hci_top.sv ====
// ********************
// Top level of the HCI queue block
// ********************
`default_nettype none

module hci_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  input  hci_reg_pkg::csr_req_t               csr_req_i,
  output hci_reg_pkg::csr_rsp_t               csr_rsp_o,

  output logic                                cmd_rvalid_o,
  input  logic                                cmd_rready_i,
  output logic [hci_queue_pkg::CmdWidth-1:0]  cmd_rdata_o,

  input  logic                                resp_wvalid_i,
  output logic                                resp_wready_o,
  input  logic [hci_queue_pkg::RespWidth-1:0] resp_wdata_i,

  output hci_queue_pkg::queue_status_t        cmd_status_o,
  output hci_queue_pkg::queue_status_t        resp_status_o
);

  logic                                cmd_push;
  logic [hci_queue_pkg::CmdWidth-1:0]  cmd_data;
  logic                                cmd_full;
  logic                                cmd_empty;
  logic                                cmd_trig;
  logic [hci_queue_pkg::ThldWidth-1:0] cmd_thld;
  logic [hci_queue_pkg::ThldWidth-1:0] cmd_thld_eff;
  logic                                cmd_flush;
  logic                                cmd_flush_done;

  logic                                resp_pop;
  logic [hci_queue_pkg::RespWidth-1:0] resp_data;
  logic                                resp_full;
  logic                                resp_empty;
  logic                                resp_trig;
  logic [hci_queue_pkg::ThldWidth-1:0] resp_thld;
  logic [hci_queue_pkg::ThldWidth-1:0] resp_thld_eff;
  logic                                resp_flush;
  logic                                resp_flush_done;

  assign cmd_rvalid_o  = ~cmd_empty;
  assign resp_wready_o = ~resp_full;  // Only back-pressure on responses

  assign cmd_status_o  = '{full: cmd_full, empty: cmd_empty,
                           thld_trig: cmd_trig, thld: cmd_thld_eff};
  assign resp_status_o = '{full: resp_full, empty: resp_empty,
                           thld_trig: resp_trig, thld: resp_thld_eff};

  hci_csr u_csr (
    .clk_i,
    .rst_ni,
    .csr_req_i,
    .csr_rsp_o,
    .cmd_push_o       (cmd_push),
    .cmd_data_o       (cmd_data),
    .cmd_full_i       (cmd_full),
    .resp_pop_o       (resp_pop),
    .resp_data_i      (resp_data),
    .resp_empty_i     (resp_empty),
    .cmd_thld_o       (cmd_thld),
    .resp_thld_o      (resp_thld),
    .cmd_thld_eff_i   (cmd_thld_eff),
    .resp_thld_eff_i  (resp_thld_eff),
    .cmd_flush_o      (cmd_flush),
    .resp_flush_o     (resp_flush),
    .cmd_flush_done_i (cmd_flush_done),
    .resp_flush_done_i(resp_flush_done)
  );

  hci_queue #(
    .Depth    (hci_queue_pkg::CmdDepth),
    .DataWidth(hci_queue_pkg::CmdWidth)
  ) u_cmd_queue (
    .clk_i,
    .rst_ni,
    .push_i      (cmd_push),
    .wdata_i     (cmd_data),
    .full_o      (cmd_full),
    .pop_i       (cmd_rvalid_o & cmd_rready_i),
    .rdata_o     (cmd_rdata_o),
    .empty_o     (cmd_empty),
    .thld_i      (cmd_thld),
    .thld_eff_o  (cmd_thld_eff),
    .thld_trig_o (cmd_trig),
    .count_free_i(1'b1),        // Free slots
    .flush_i     (cmd_flush),
    .flush_done_o(cmd_flush_done)
  );

  hci_queue #(
    .Depth    (hci_queue_pkg::RespDepth),
    .DataWidth(hci_queue_pkg::RespWidth)
  ) u_resp_queue (
    .clk_i,
    .rst_ni,
    .push_i      (resp_wvalid_i & resp_wready_o),
    .wdata_i     (resp_wdata_i),
    .full_o      (resp_full),
    .pop_i       (resp_pop),
    .rdata_o     (resp_data),
    .empty_o     (resp_empty),
    .thld_i      (resp_thld),
    .thld_eff_o  (resp_thld_eff),
    .thld_trig_o (resp_trig),
    .count_free_i(1'b0),        // Stored entries
    .flush_i     (resp_flush),
    .flush_done_o(resp_flush_done)
  );

endmodule

`default_nettype wire

// ==== test/hci_sva.sv ====
// ********************
// Handshake and status assertions, bound to the top level
// ********************
`default_nettype none

module hci_sva (
  input logic                         clk_i,
  input logic                         rst_ni,
  input hci_reg_pkg::csr_req_t        csr_req_i,
  input hci_reg_pkg::csr_rsp_t        csr_rsp_o,
  input logic                         cmd_rvalid_o,
  input hci_queue_pkg::queue_status_t cmd_status_o,
  input hci_queue_pkg::queue_status_t resp_status_o
);
  timeunit 1ns;
  timeprecision 100ps;

  a_ack_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_req_i.req |=> (csr_rsp_o.rd_ack || csr_rsp_o.wr_ack))
    else $error("request not acknowledged one cycle later");

  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (csr_rsp_o.rd_ack || csr_rsp_o.wr_ack) |-> $past(csr_req_i.req))
    else $error("ack without a request");

  a_one_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(csr_rsp_o.rd_ack && csr_rsp_o.wr_ack))
    else $error("read and write ack at once");

  a_rvalid_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_rvalid_o == !cmd_status_o.empty)
    else $error("cmd_rvalid_o disagrees with empty");

  a_cmd_full_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(cmd_status_o.full && cmd_status_o.empty))
    else $error("command queue full and empty");

  a_resp_full_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(resp_status_o.full && resp_status_o.empty))
    else $error("response queue full and empty");

endmodule

bind hci_top hci_sva u_sva (
  .clk_i,
  .rst_ni,
  .csr_req_i,
  .csr_rsp_o,
  .cmd_rvalid_o,
  .cmd_status_o,
  .resp_status_o
);

`default_nettype wire

// ==== test/hci_tb.sv ====
// ********************
// Testbench of the HCI queue block, runs the operations listed in the case file
// ********************
`default_nettype none

module hci_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned DriveDelay = 1;
  localparam int unsigned WaitLimit  = 20;  // Cycles per wait

  logic                                clk_i;
  logic                                rst_ni;
  hci_reg_pkg::csr_req_t               csr_req;
  hci_reg_pkg::csr_rsp_t               csr_rsp;
  logic                                cmd_rvalid;
  logic                                cmd_rready;
  logic [hci_queue_pkg::CmdWidth-1:0]  cmd_rdata;
  logic                                resp_wvalid;
  logic                                resp_wready;
  logic [hci_queue_pkg::RespWidth-1:0] resp_wdata;
  hci_queue_pkg::queue_status_t        cmd_status;
  hci_queue_pkg::queue_status_t        resp_status;

  hci_top dut_i (
    .clk_i,
    .rst_ni,
    .csr_req_i    (csr_req),
    .csr_rsp_o    (csr_rsp),
    .cmd_rvalid_o (cmd_rvalid),
    .cmd_rready_i (cmd_rready),
    .cmd_rdata_o  (cmd_rdata),
    .resp_wvalid_i(resp_wvalid),
    .resp_wready_o(resp_wready),
    .resp_wdata_i (resp_wdata),
    .cmd_status_o (cmd_status),
    .resp_status_o(resp_status)
  );

  always #20 clk_i = ~clk_i;

  task automatic next_cycle();
    @(posedge clk_i);
    #DriveDelay;
  endtask

  task automatic fail_run(input string why);
    $display("%0t: %s", $time, why);
    $display("CHECKS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // One request pulse, then wait for its ack
  task automatic csr_access(input logic is_wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic err, output logic [31:0] rdata);
    int unsigned waited;
    next_cycle();
    csr_req = '{req: 1'b1, is_wr: is_wr, addr: addr, wdata: wdata};
    next_cycle();
    csr_req.req = 1'b0;
    waited = 0;
    while (!(csr_rsp.rd_ack || csr_rsp.wr_ack)) begin
      if (waited == WaitLimit) fail_run($sformatf("no CSR ack for address %0h", addr));
      next_cycle();
      waited++;
    end
    check("csr_rsp_o.wr_ack", csr_rsp.wr_ack, is_wr);
    err   = csr_rsp.err;
    rdata = csr_rsp.rdata;
  endtask

  // Dword pairs base+2i (low) and base+2i+1 (high)
  task automatic push_cmds(input int unsigned n, input logic [31:0] base, input logic exp_err);
    logic        err;
    logic [31:0] rdata;
    for (int unsigned i = 0; i < n; i++) begin
      csr_access(1'b1, hci_reg_pkg::RegCmdPort, base + 2 * i, err, rdata);
      check("csr_rsp_o.err", err, 1'b0);
      csr_access(1'b1, hci_reg_pkg::RegCmdPort, base + 2 * i + 1, err, rdata);
      check("csr_rsp_o.err", err, exp_err);
    end
  endtask

  task automatic pop_cmds(input int unsigned n, input logic [31:0] base);
    int unsigned waited;
    logic [31:0] lo;
    logic [31:0] hi;
    for (int unsigned i = 0; i < n; i++) begin
      lo = base + 2 * i;
      hi = lo + 1;
      next_cycle();
      waited = 0;
      while (!cmd_rvalid) begin
        if (waited == WaitLimit) fail_run("command queue never presented a command");
        next_cycle();
        waited++;
      end
      check("cmd_rdata_o", cmd_rdata, {hi, lo});
      cmd_rready = 1'b1;
      next_cycle();
      cmd_rready = 1'b0;
    end
  endtask

  task automatic push_resps(input int unsigned n, input logic [31:0] base, input logic exp_rdy);
    int unsigned waited;
    for (int unsigned i = 0; i < n; i++) begin
      next_cycle();
      waited = 0;
      while (!resp_wready) begin
        if (waited == WaitLimit) fail_run("response queue never accepted a response");
        next_cycle();
        waited++;
      end
      resp_wvalid = 1'b1;
      resp_wdata  = base + i;
      next_cycle();
      resp_wvalid = 1'b0;
    end
    check("resp_wready_o", resp_wready, exp_rdy);
  endtask

  // Empty queue reads give err with zero data
  task automatic pop_resps(input int unsigned n, input logic [31:0] base, input logic exp_err);
    logic        err;
    logic [31:0] rdata;
    for (int unsigned i = 0; i < n; i++) begin
      csr_access(1'b0, hci_reg_pkg::RegRespPort, '0, err, rdata);
      check("csr_rsp_o.err", err, exp_err);
      check("csr_rsp_o.rdata", rdata, exp_err ? 32'h0 : base + i);
    end
  endtask

  task automatic poll_reg(input logic [11:0] addr, input logic [31:0] exp,
                          input int unsigned max_reads);
    logic        err;
    logic [31:0] rdata;
    int unsigned reads;
    reads = 0;
    do begin
      if (reads == max_reads) fail_run($sformatf("register %0h did not settle to %0h", addr, exp));
      csr_access(1'b0, addr, '0, err, rdata);
      check("csr_rsp_o.err", err, 1'b0);
      reads++;
    end while (rdata != exp);
  endtask

  task automatic run_case(input string op, input logic [63:0] a, input logic [63:0] d,
                          input logic [63:0] e);
    logic        err;
    logic [31:0] rdata;
    case (op)
      "wr": begin
        csr_access(1'b1, a[11:0], d[31:0], err, rdata);
        check("csr_rsp_o.err", err, e);
      end
      "rd": begin
        csr_access(1'b0, a[11:0], '0, err, rdata);
        check("csr_rsp_o.err", err, e);
        check("csr_rsp_o.rdata", rdata, d);
      end
      "st": begin
        if (a == 0) check("cmd_status_o", cmd_status, d);
        else check("resp_status_o", resp_status, d);
      end
      "poll":  poll_reg(a[11:0], d[31:0], e);
      "cpush": push_cmds(a, d[31:0], e[0]);
      "cpop":  pop_cmds(a, d[31:0]);
      "rpush": push_resps(a, d[31:0], e[0]);
      "rpop":  pop_resps(a, d[31:0], e[0]);
      default: fail_run($sformatf("unknown operation %s in case file", op));
    endcase
  endtask

  initial begin
    int          fd;
    int          fields;
    string       line;
    string       op;
    logic [63:0] a;
    logic [63:0] d;
    logic [63:0] e;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    csr_req     = '0;
    cmd_rready  = 1'b0;
    resp_wvalid = 1'b0;
    resp_wdata  = '0;
    repeat (16) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;

    check("csr_rsp_o.rd_ack", csr_rsp.rd_ack, 1'b0);
    check("csr_rsp_o.wr_ack", csr_rsp.wr_ack, 1'b0);
    check("cmd_rvalid_o", cmd_rvalid, 1'b0);
    check("resp_wready_o", resp_wready, 1'b1);

    fd = $fopen("test/hci_cases.txt", "r");
    if (fd == 0) fail_run("cannot open test/hci_cases.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;  // Header and blank lines
      fields = $sscanf(line, "%s %h %h %h", op, a, d, e);
      if (fields != 4) fail_run($sformatf("malformed case line: %s", line));
      run_case(op, a, d, e);
    end
    $fclose(fd);

    repeat (2) next_cycle();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/hci_cases.txt ====
# op     addr/count  data        expect  (hex)
# wr,rd: err | st: 0 cmd, 1 resp status | poll: max reads | cpush,rpop: err | rpush: wready after
st       0      301         0
st       1      201         0
cpush    2      a0000000    0
st       0      101         0
cpop     2      a0000000    0
rpush    2      c0de0000    1
rpop     2      c0de0000    0
rpop     1      0           1
wr       020    00000014    0
rd       020    00000108    0
st       0      308         0
st       1      201         0
wr       020    00000403    0
rd       020    00000403    0
cpush    5      b0000000    0
st       0      103         0
cpush    1      b000000a    0
st       0      003         0
cpush    2      b000000c    0
st       0      403         0
cpush    1      b0000010    1
cpop     8      b0000000    0
st       0      303         0
rpush    3      d0000000    1
st       1      004         0
rpush    1      d0000003    1
st       1      104         0
rpush    4      d0000004    0
st       1      504         0
rpop     1      d0000000    0
st       1      104         0
rpush    1      d0000008    0
rpop     8      d0000001    0
st       1      204         0
rpop     1      0           1
wr       020    00000101    0
cpush    2      e0000000    0
wr       030    deadbeef    0
rpush    3      f0000000    1
st       0      101         0
st       1      101         0
wr       010    00000006    0
poll     010    00000000    2
st       0      301         0
st       1      201         0
cpush    1      e1000000    0
cpop     1      e1000000    0
wr       040    00000000    1
rd       040    00000000    1
wr       034    12345678    1
rd       030    00000000    1

// ==== filelist.f ====
src/hci_reg_pkg.sv
src/hci_queue_pkg.sv
src/hci_queue.sv
src/hci_csr.sv
src/hci_top.sv
test/hci_sva.sv
test/hci_tb.sv

// ==== Bender.yml ====
package:
  name: hci_queue

sources:
  # Packages first, then the queue, register block and top level
  - target: any(rtl, test)
    files:
      - src/hci_reg_pkg.sv
      - src/hci_queue_pkg.sv
      - src/hci_queue.sv
      - src/hci_csr.sv
      - src/hci_top.sv

  - target: test
    files:
      - test/hci_sva.sv
      - test/hci_tb.sv
